// ==== build.f ====
rtl/crom_pkg.sv
rtl/alu_pkg.sv
rtl/alu_regfile.sv
rtl/alu_operand_core.sv
rtl/alu_ram_shifter.sv
rtl/alu_q_register.sv
rtl/alu_slice.sv
test/tb_alu_slice.sv

// ==== Bender.yml ====
package:
  name: alu_slice

sources:
  # Packages first, then the datapath blocks and the top level
  - rtl/crom_pkg.sv
  - rtl/alu_pkg.sv
  - rtl/alu_regfile.sv
  - rtl/alu_operand_core.sv
  - rtl/alu_ram_shifter.sv
  - rtl/alu_q_register.sv
  - rtl/alu_slice.sv

  - target: test
    files:
      - test/tb_alu_slice.sv

# Top levels
#   tb_alu_slice  simulation
#   alu_slice     synthesis
#

// ==== test/tb_alu_slice.sv ====
module tb_alu_slice;

   logic                              clk;
   logic                              rst;
   logic [0:alu_pkg::bus_width-1]     dbus;
   crom_pkg::alu_fun_e                fun;
   crom_pkg::alu_src_e                lsrc;
   crom_pkg::alu_src_e                rsrc;
   crom_pkg::alu_dst_e                dst;
   crom_pkg::shstyle_e                shstyle;
   logic                              clkl;
   logic                              clkr;
   logic [0:alu_pkg::rf_addr_width-1] aa;
   logic [0:alu_pkg::rf_addr_width-1] ba;
   logic                              ci;
   logic                              multi_shift;
   logic                              divide_shift;
   logic [0:alu_pkg::bus_width-1]     t;
   logic                              smear;
   logic                              co;
   logic                              ovfl;
   logic                              sign;
   logic                              lz;
   logic                              hz;

   // Reference state
   logic [0:39] m_rf [0:15];
   logic [0:39] m_q;
   logic [0:39] e_f;      // Expected function result
   logic [0:39] e_y;      // Expected Y
   logic [0:39] e_w;      // Expected RAM write data
   logic [0:39] e_qn;     // Expected next Q
   logic        e_co;
   logic        e_wr;
   int          errors = 0;
   int          checks = 0;
   bit          released;

   alu_slice i_dut (.clk, .rst, .dbus, .fun, .lsrc, .rsrc, .dst, .shstyle, .clkl, .clkr,
                    .aa, .ba, .ci, .multi_shift, .divide_shift, .t, .smear, .co, .ovfl,
                    .sign, .lz, .hz);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      rst = 1'b1;
      repeat (4) @(posedge clk);
      #1 rst = 1'b0;
   end

   task automatic check_value(input string what, input logic [39:0] got,
                              input logic [39:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   task automatic model_eval();
      logic [0:39] a;
      logic [0:39] b;
      logic [0:39] dd;
      logic [0:39] r;
      logic [0:39] s;
      logic [0:39] f;
      logic [0:40] res;     // Carry in front
      logic        fill;
      crom_pkg::alu_src_e sel;
      a  = m_rf[aa];
      b  = m_rf[ba];
      dd = {{2{dbus[0]}}, dbus, 2'b00};
      for (int h = 0; h < 40; h += 20)
      begin
         sel = (h == 0) ? lsrc : rsrc;
         if (sel inside {crom_pkg::src_aq, crom_pkg::src_ab})
            r[h +: 20] = a[h +: 20];
         else if (sel inside {crom_pkg::src_da, crom_pkg::src_dq, crom_pkg::src_dz})
            r[h +: 20] = dd[h +: 20];
         else
            r[h +: 20] = '0;
         if (sel inside {crom_pkg::src_aq, crom_pkg::src_zq, crom_pkg::src_dq})
            s[h +: 20] = m_q[h +: 20];
         else if (sel inside {crom_pkg::src_ab, crom_pkg::src_zb})
            s[h +: 20] = b[h +: 20];
         else if (sel == crom_pkg::src_dz)
            s[h +: 20] = '0;
         else
            s[h +: 20] = a[h +: 20];
      end
      case (fun)
         crom_pkg::fun_add:   res = {1'b0, r} + {1'b0, s} + ci;
         crom_pkg::fun_subr:  res = {1'b0, r} + {1'b0, ~s} + ci;
         crom_pkg::fun_subs:  res = {1'b0, s} + {1'b0, ~r} + ci;
         crom_pkg::fun_orrs:  res = {1'b0, r | s};
         crom_pkg::fun_andrs: res = {1'b0, r & s};
         crom_pkg::fun_notrs: res = {1'b0, ~r & s};
         crom_pkg::fun_exor:  res = {1'b0, r ^ s};
         default:             res = {1'b0, ~(r ^ s)};
      endcase
      e_co = res[0];
      f    = res[1:40];
      e_f  = f;
      e_y  = (dst == crom_pkg::dst_rama) ? a : f;
      e_wr = !(dst inside {crom_pkg::dst_qreg, crom_pkg::dst_nop});
      e_w  = f;
      if (dst inside {crom_pkg::dst_ramqu, crom_pkg::dst_ramu})
      begin
         case (shstyle)
            crom_pkg::sh_norm: fill = multi_shift;
            crom_pkg::sh_zero: fill = 1'b0;
            crom_pkg::sh_ones: fill = 1'b1;
            crom_pkg::sh_rot:  fill = f[4];
            default:           fill = m_q[4];
         endcase
         e_w = {f[1:39], fill};
         if (!(shstyle inside {crom_pkg::sh_norm, crom_pkg::sh_lshc, crom_pkg::sh_div}))
            e_w[3] = e_y[0];
      end
      else if (dst inside {crom_pkg::dst_ramqd, crom_pkg::dst_ramd})
      begin
         e_w = {f[0], f[0:38]};
         case (shstyle)
            crom_pkg::sh_zero, crom_pkg::sh_lshc: e_w[3] = 1'b0;
            crom_pkg::sh_ones, crom_pkg::sh_div:  e_w[3] = 1'b1;
            crom_pkg::sh_rot:  e_w[3] = f[39];
            crom_pkg::sh_rotc: e_w[3] = m_q[39];
            default:           e_w[3] = f[2];
         endcase
      end
      e_qn = m_q;   // Hold unless loaded or shifted
      if (dst == crom_pkg::dst_qreg)
         e_qn = f;
      else if (dst == crom_pkg::dst_ramqu)
      begin
         case (shstyle)
            crom_pkg::sh_ones: fill = 1'b1;
            crom_pkg::sh_rot:  fill = m_q[4];
            crom_pkg::sh_div:  fill = divide_shift;
            crom_pkg::sh_rotc: fill = f[4];
            default:           fill = 1'b0;
         endcase
         e_qn = {m_q[1:39], fill};
      end
      else if (dst == crom_pkg::dst_ramqd && shstyle == crom_pkg::sh_norm)
         e_qn = {1'b0, f[0:38]};
      else if (dst == crom_pkg::dst_ramqd)
      begin
         e_qn = {1'b0, m_q[0:38]};
         case (shstyle)
            crom_pkg::sh_zero: e_qn[3] = 1'b0;
            crom_pkg::sh_ones: e_qn[3] = 1'b1;
            crom_pkg::sh_rot:  e_qn[3] = m_q[39];
            default:           e_qn[3] = f[39];
         endcase
      end
   endtask

   // Called 1 unit after a rising edge with the microword applied
   task automatic apply_and_check();
      logic [0:3] wa;
      logic [0:1] en;
      #4;
      model_eval();
      check_value("t", t, e_y[2:37]);
      check_value("smear", smear, e_y[1]);
      check_value("co", co, e_co);
      check_value("sign", sign, e_f[0]);
      check_value("ovfl", ovfl, e_co != e_f[0]);
      check_value("lz", lz, e_f[0:19] == '0);
      check_value("hz", hz, e_f[20:39] == '0);
      wa = ba;
      en = {clkl, clkr};
      @(posedge clk);
      for (int h = 0; h < 2; h++)
         if (en[h])
         begin
            if (e_wr)
               m_rf[wa][h*20 +: 20] = e_w[h*20 +: 20];
            m_q[h*20 +: 20] = e_qn[h*20 +: 20];
         end
      #1;
   endtask

   task automatic randomize_word();
      dbus         = 36'({$urandom, $urandom});
      fun          = crom_pkg::alu_fun_e'($urandom_range(7));
      lsrc         = crom_pkg::alu_src_e'($urandom_range(7));
      rsrc         = crom_pkg::alu_src_e'($urandom_range(7));
      dst          = crom_pkg::alu_dst_e'($urandom_range(7));
      shstyle      = crom_pkg::shstyle_e'($urandom_range(7));
      clkl         = 1'($urandom);
      clkr         = 1'($urandom);
      aa           = 4'($urandom);
      ba           = 4'($urandom);
      ci           = 1'($urandom);
      multi_shift  = 1'($urandom);
      divide_shift = 1'($urandom);
   endtask

   // Reads every register through the A port, then Q
   task automatic read_all();
      for (int i = 0; i < 16; i++)
      begin
         randomize_word();
         lsrc = crom_pkg::src_za;
         rsrc = crom_pkg::src_za;
         fun  = crom_pkg::fun_orrs;
         dst  = crom_pkg::dst_nop;
         aa   = 4'(i);
         apply_and_check();
      end
      lsrc = crom_pkg::src_zq;
      rsrc = crom_pkg::src_zq;
      apply_and_check();
   endtask

   task automatic wait_reset_release(output bit ok);
      int n;
      n = 0;
      while (rst !== 1'b0 && n < 20)
      begin
         @(posedge clk);
         n++;
      end
      ok = (rst === 1'b0);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(68));
      {dbus, aa, ba, ci, clkl, clkr, multi_shift, divide_shift} = '0;
      fun     = crom_pkg::fun_orrs;
      lsrc    = crom_pkg::src_dz;
      rsrc    = crom_pkg::src_dz;
      dst     = crom_pkg::dst_nop;
      shstyle = crom_pkg::sh_norm;
      m_q     = '0;
      for (int i = 0; i < 16; i++)
         m_rf[i] = '0;
      wait_reset_release(released);
      if (!released)
      begin
         $display("Reset was still asserted after 20 clock cycles");
         $display("Verification failed");
      end
      else
      begin
         #5;   // Mid-cycle with the idle microword
         check_value("t after reset", t, 0);
         check_value("lz after reset", lz, 1);
         check_value("hz after reset", hz, 1);
         check_value("co after reset", co, 0);
         #6 apply_and_check();
         for (int i = 0; i < 16; i++)   // Load through ramf
         begin
            randomize_word();
            lsrc = crom_pkg::src_dz;
            rsrc = crom_pkg::src_dz;
            fun  = crom_pkg::fun_orrs;
            dst  = crom_pkg::dst_ramf;
            {ba, clkl, clkr} = {4'(i), 2'b11};
            apply_and_check();
         end
         dst = crom_pkg::dst_qreg;
         apply_and_check();
         read_all();
         repeat (40)   // Half enables
         begin
            randomize_word();
            dst = $urandom_range(1) ? crom_pkg::dst_ramf : crom_pkg::dst_qreg;
            apply_and_check();
         end
         read_all();
         for (int fn = 0; fn < 8; fn++)
            repeat (20)
            begin
               randomize_word();
               fun = crom_pkg::alu_fun_e'(fn);
               apply_and_check();
            end
         for (int st = 0; st < 8; st++)
         begin
            for (int k = 0; k < 4; k++)
               repeat (3)
               begin
                  randomize_word();
                  shstyle = crom_pkg::shstyle_e'(st);
                  dst     = crom_pkg::alu_dst_e'(4 + k);   // ramqd up to ramu
                  {clkl, clkr} = 2'b11;
                  apply_and_check();
               end
            read_all();
         end
         repeat (2000)
         begin
            randomize_word();
            apply_and_check();
         end
         $display("Checks run: %0d, errors: %0d", checks, errors);
         if (errors == 0)
            $display("Verification passed");
         else
            $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== rtl/alu_slice.sv ====
module alu_slice (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [0:alu_pkg::bus_width-1]     dbus,
   input  crom_pkg::alu_fun_e                fun,
   input  crom_pkg::alu_src_e                lsrc,
   input  crom_pkg::alu_src_e                rsrc,
   input  crom_pkg::alu_dst_e                dst,
   input  crom_pkg::shstyle_e                shstyle,
   input  logic                              clkl,
   input  logic                              clkr,
   input  logic [0:alu_pkg::rf_addr_width-1] aa,
   input  logic [0:alu_pkg::rf_addr_width-1] ba,
   input  logic                              ci,
   input  logic                              multi_shift,
   input  logic                              divide_shift,
   output logic [0:alu_pkg::bus_width-1]     t,
   output logic                              smear,
   output logic                              co,
   output logic                              ovfl,
   output logic                              sign,
   output logic                              lz,
   output logic                              hz
);

   logic [0:alu_pkg::dp_width-1] a_data;
   logic [0:alu_pkg::dp_width-1] b_data;
   logic [0:alu_pkg::dp_width-1] q_data;
   logic [0:alu_pkg::dp_width-1] f;
   logic [0:alu_pkg::dp_width-1] y;
   logic [0:alu_pkg::dp_width-1] wdata;   // RAM shifter output
   logic                         wr_en;

   ////////////////////////////////////////////////////////////
   // Datapath blocks
   ////////////////////////////////////////////////////////////

   alu_regfile u_regfile (.clk, .rst, .aa, .ba, .wr_en, .clkl, .clkr, .wdata,
                          .a_data, .b_data);

   alu_operand_core u_core (.a_data, .b_data, .q_data, .dbus, .lsrc, .rsrc, .fun,
                            .dst, .ci, .f, .y, .co, .ovfl, .sign, .lz, .hz);

   alu_ram_shifter u_shifter (.f, .y, .q_data, .dst, .shstyle, .sign,
                              .multi_shift, .wdata, .wr_en);

   alu_q_register u_qreg (.clk, .rst, .clkl, .clkr, .dst, .shstyle, .f,
                          .divide_shift, .q_data);

   // Drop the two pad bits on each side
   assign smear = y[1];
   assign t     = y[2:alu_pkg::bus_width+1];

endmodule

// ==== rtl/alu_q_register.sv ====
module alu_q_register (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clkl,
   input  logic                         clkr,
   input  crom_pkg::alu_dst_e           dst,
   input  crom_pkg::shstyle_e           shstyle,
   input  logic [0:alu_pkg::dp_width-1] f,
   input  logic                         divide_shift,
   output logic [0:alu_pkg::dp_width-1] q_data
);

   logic [0:alu_pkg::dp_width-1] q_next;
   logic [0:1]                   half_en;
   logic                         up_fill;
   logic                         dn_bit3;

   assign half_en = {clkl, clkr};

   ////////////////////////////////////////////////////////////
   // Q shifter
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (shstyle)
         crom_pkg::sh_ones: up_fill = 1'b1;
         crom_pkg::sh_rot:  up_fill = q_data[4];
         crom_pkg::sh_div:  up_fill = divide_shift;   // Quotient bit
         crom_pkg::sh_rotc: up_fill = f[4];
         default:           up_fill = 1'b0;
      endcase
      case (shstyle)
         crom_pkg::sh_norm: dn_bit3 = f[2];
         crom_pkg::sh_zero: dn_bit3 = 1'b0;
         crom_pkg::sh_ones: dn_bit3 = 1'b1;
         crom_pkg::sh_rot:  dn_bit3 = q_data[alu_pkg::dp_width-1];
         default:           dn_bit3 = f[alu_pkg::dp_width-1];
      endcase

      case (dst)
         crom_pkg::dst_qreg:  q_next = f;
         crom_pkg::dst_ramqu: q_next = {q_data[1:alu_pkg::dp_width-1], up_fill};
         crom_pkg::dst_ramqd:
         begin
            if (shstyle == crom_pkg::sh_norm)
               q_next = {1'b0, f[0:alu_pkg::dp_width-2]};
            else
               q_next = {1'b0, q_data[0:alu_pkg::dp_width-2]};
            q_next[3] = dn_bit3;
         end
         default: q_next = q_data;   // Hold
      endcase
   end

   for (genvar h = 0; h < 2; h++)
   begin : g_half
      always_ff @(posedge clk or posedge rst)
      begin
         if (rst)
            q_data[h*alu_pkg::half_width +: alu_pkg::half_width] <= '0;
         else if (half_en[h])
            q_data[h*alu_pkg::half_width +: alu_pkg::half_width] <=
               q_next[h*alu_pkg::half_width +: alu_pkg::half_width];
      end
   end

   a_ctrl_known : assert property (@(posedge clk) disable iff (rst)
      (clkl || clkr) |-> !$isunknown({dst, shstyle}));

endmodule

// ==== rtl/alu_ram_shifter.sv ====
module alu_ram_shifter (
   input  logic [0:alu_pkg::dp_width-1] f,
   input  logic [0:alu_pkg::dp_width-1] y,
   input  logic [0:alu_pkg::dp_width-1] q_data,
   input  crom_pkg::alu_dst_e           dst,
   input  crom_pkg::shstyle_e           shstyle,
   input  logic                         sign,
   input  logic                         multi_shift,
   output logic [0:alu_pkg::dp_width-1] wdata,
   output logic                         wr_en
);

   logic up;
   logic down;
   logic up_fill;    // Enters at bit 39
   logic up_mark;    // Y bit 0 replaces bit 3
   logic dn_bit3;

   assign up   = (dst == crom_pkg::dst_ramqu) || (dst == crom_pkg::dst_ramu);
   assign down = (dst == crom_pkg::dst_ramqd) || (dst == crom_pkg::dst_ramd);

   // Every destination but Q load and nop writes RAM
   assign wr_en = (dst != crom_pkg::dst_qreg) && (dst != crom_pkg::dst_nop);

   assign up_mark = !(shstyle inside {crom_pkg::sh_norm, crom_pkg::sh_lshc, crom_pkg::sh_div});

   always_comb
   begin
      case (shstyle)
         crom_pkg::sh_norm: up_fill = multi_shift;
         crom_pkg::sh_zero: up_fill = 1'b0;
         crom_pkg::sh_ones: up_fill = 1'b1;
         crom_pkg::sh_rot:  up_fill = f[4];
         default:           up_fill = q_data[4];   // Ashc, lshc, div, rotc
      endcase
      case (shstyle)
         crom_pkg::sh_zero, crom_pkg::sh_lshc: dn_bit3 = 1'b0;
         crom_pkg::sh_ones, crom_pkg::sh_div:  dn_bit3 = 1'b1;
         crom_pkg::sh_rot:  dn_bit3 = f[alu_pkg::dp_width-1];
         crom_pkg::sh_rotc: dn_bit3 = q_data[alu_pkg::dp_width-1];
         default:           dn_bit3 = f[2];        // Plain shift
      endcase

      wdata = f;
      if (up)
      begin
         wdata = {f[1:alu_pkg::dp_width-1], up_fill};
         if (up_mark)
            wdata[3] = y[0];
      end
      else if (down)
      begin
         wdata    = {sign, f[0:alu_pkg::dp_width-2]};   // Sign enters at bit 0
         wdata[3] = dn_bit3;
      end
   end

endmodule

// ==== rtl/alu_operand_core.sv ====
module alu_operand_core (
   input  logic [0:alu_pkg::dp_width-1]  a_data,
   input  logic [0:alu_pkg::dp_width-1]  b_data,
   input  logic [0:alu_pkg::dp_width-1]  q_data,
   input  logic [0:alu_pkg::bus_width-1] dbus,
   input  crom_pkg::alu_src_e            lsrc,
   input  crom_pkg::alu_src_e            rsrc,
   input  crom_pkg::alu_fun_e            fun,
   input  crom_pkg::alu_dst_e            dst,
   input  logic                          ci,
   output logic [0:alu_pkg::dp_width-1]  f,
   output logic [0:alu_pkg::dp_width-1]  y,
   output logic                          co,
   output logic                          ovfl,
   output logic                          sign,
   output logic                          lz,
   output logic                          hz
);

   logic [0:alu_pkg::dp_width-1] dd;   // Extended data bus
   logic [0:alu_pkg::dp_width-1] r;
   logic [0:alu_pkg::dp_width-1] s;
   logic [0:alu_pkg::dp_width]   res;  // Bit 0 is carry

   // R operand for one half
   function automatic logic [0:alu_pkg::half_width-1] pick_r(
      input crom_pkg::alu_src_e             src,
      input logic [0:alu_pkg::half_width-1] a,
      input logic [0:alu_pkg::half_width-1] d);
      case (src)
         crom_pkg::src_aq, crom_pkg::src_ab: pick_r = a;
         crom_pkg::src_zq, crom_pkg::src_zb, crom_pkg::src_za: pick_r = '0;
         default: pick_r = d;
      endcase
   endfunction

   // S operand for one half
   function automatic logic [0:alu_pkg::half_width-1] pick_s(
      input crom_pkg::alu_src_e             src,
      input logic [0:alu_pkg::half_width-1] a,
      input logic [0:alu_pkg::half_width-1] b,
      input logic [0:alu_pkg::half_width-1] q);
      case (src)
         crom_pkg::src_aq, crom_pkg::src_zq, crom_pkg::src_dq: pick_s = q;
         crom_pkg::src_ab, crom_pkg::src_zb: pick_s = b;
         crom_pkg::src_za, crom_pkg::src_da: pick_s = a;
         default: pick_s = '0;
      endcase
   endfunction

   assign dd = {{2{dbus[0]}}, dbus, 2'b00};   // Sign extend, pad right

   assign r = {pick_r(lsrc, a_data[0 +: 20], dd[0 +: 20]),
               pick_r(rsrc, a_data[20 +: 20], dd[20 +: 20])};
   assign s = {pick_s(lsrc, a_data[0 +: 20], b_data[0 +: 20], q_data[0 +: 20]),
               pick_s(rsrc, a_data[20 +: 20], b_data[20 +: 20], q_data[20 +: 20])};

   ////////////////////////////////////////////////////////////
   // Function unit
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (fun)
         crom_pkg::fun_add:   res = {1'b0, r} + {1'b0, s} + ci;
         crom_pkg::fun_subr:  res = {1'b0, r} + {1'b0, ~s} + ci;
         crom_pkg::fun_subs:  res = {1'b0, s} + {1'b0, ~r} + ci;
         crom_pkg::fun_orrs:  res = {1'b0, r | s};
         crom_pkg::fun_andrs: res = {1'b0, r & s};
         crom_pkg::fun_notrs: res = {1'b0, ~r & s};
         crom_pkg::fun_exor:  res = {1'b0, r ^ s};
         default:             res = {1'b0, ~(r ^ s)};   // Exnor
      endcase
   end

   assign co   = res[0];
   assign f    = res[1:alu_pkg::dp_width];
   assign sign = f[0];
   assign ovfl = co != sign;
   assign lz   = f[0 +: alu_pkg::half_width] == '0;
   assign hz   = f[alu_pkg::half_width +: alu_pkg::half_width] == '0;

   assign y = (dst == crom_pkg::dst_rama) ? a_data : f;   // Destination mux

endmodule

// ==== rtl/alu_regfile.sv ====
module alu_regfile (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [0:alu_pkg::rf_addr_width-1] aa,
   input  logic [0:alu_pkg::rf_addr_width-1] ba,
   input  logic                              wr_en,
   input  logic                              clkl,
   input  logic                              clkr,
   input  logic [0:alu_pkg::dp_width-1]      wdata,
   output logic [0:alu_pkg::dp_width-1]      a_data,
   output logic [0:alu_pkg::dp_width-1]      b_data
);

   logic [0:1] half_en;   // Left half first

   assign half_en = {clkl, clkr};

   ////////////////////////////////////////////////////////////
   // One register array per half
   ////////////////////////////////////////////////////////////

   for (genvar h = 0; h < 2; h++)
   begin : g_half
      logic [0:alu_pkg::half_width-1] mem [0:alu_pkg::rf_depth-1];

      always_ff @(posedge clk or posedge rst)
      begin
         if (rst)
            for (int i = 0; i < alu_pkg::rf_depth; i++)
               mem[i] <= '0;
         else if (wr_en && half_en[h])
            mem[ba] <= wdata[h*alu_pkg::half_width +: alu_pkg::half_width];
      end

      // Asynchronous reads
      assign a_data[h*alu_pkg::half_width +: alu_pkg::half_width] = mem[aa];
      assign b_data[h*alu_pkg::half_width +: alu_pkg::half_width] = mem[ba];
   end

   // Write data must be clean before it lands in either half
   a_wdata_known : assert property (@(posedge clk) disable iff (rst)
      (wr_en && (clkl || clkr)) |-> !$isunknown(wdata));

endmodule

// ==== rtl/alu_pkg.sv ====
package alu_pkg;

   ////////////////////////////////////////////////////////////
   // Datapath geometry
   ////////////////////////////////////////////////////////////

   localparam int dp_width   = 40;   // Two sign bits, 36 data, two pad
   localparam int half_width = 20;   // Left or right half
   localparam int bus_width  = 36;

   // Register file
   localparam int rf_depth      = 16;
   localparam int rf_addr_width = 4;

endpackage

// ==== rtl/crom_pkg.sv ====
package crom_pkg;

   ////////////////////////////////////////////////////////////
   // Microword fields
   ////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      fun_add   = 3'd0,   // R + S + ci
      fun_subr  = 3'd1,   // R - S
      fun_subs  = 3'd2,   // S - R
      fun_orrs  = 3'd3,
      fun_andrs = 3'd4,
      fun_notrs = 3'd5,   // ~R & S
      fun_exor  = 3'd6,
      fun_exnor = 3'd7
   } alu_fun_e;

   // Operand pair named as R,S
   typedef enum logic [2:0] {
      src_aq = 3'd0,
      src_ab = 3'd1,
      src_zq = 3'd2,
      src_zb = 3'd3,
      src_za = 3'd4,
      src_da = 3'd5,
      src_dq = 3'd6,
      src_dz = 3'd7
   } alu_src_e;

   typedef enum logic [2:0] {
      dst_qreg  = 3'd0,   // F to Q, no RAM write
      dst_nop   = 3'd1,
      dst_rama  = 3'd2,   // Y is A port
      dst_ramf  = 3'd3,
      dst_ramqd = 3'd4,   // RAM and Q shift down
      dst_ramd  = 3'd5,
      dst_ramqu = 3'd6,   // RAM and Q shift up
      dst_ramu  = 3'd7
   } alu_dst_e;

   typedef enum logic [2:0] {
      sh_norm = 3'd0,
      sh_zero = 3'd1,
      sh_ones = 3'd2,
      sh_rot  = 3'd3,
      sh_ashc = 3'd4,
      sh_lshc = 3'd5,
      sh_div  = 3'd6,
      sh_rotc = 3'd7
   } shstyle_e;

endpackage
